//--- design/dma_burst_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module dma_burst_issuer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [31:0]       cfg_base,
	input  logic [31:0]       cfg_len,
	input  logic              cfg_enable,
	input  logic              restart,
	input  logic              mem_credit,
	input  logic              beat_taken,
	input  logic [5:0]        fifo_free,
	output logic              mem_req_valid,
	output dma_pkg::mem_req_t mem_req
);

	logic [31:0] next_addr;   // Address of the next burst
	logic [31:0] req_addr;
	logic [31:0] addr_step;
	logic [31:0] region_end;
	logic [31:0] addr_after;
	logic [2:0]  credits;
	logic [5:0]  reserved;    // Beats issued but not yet received
	logic        have_credit;
	logic        space_ok;
	logic        issue;

	// A restart overrides the stored walk position
	assign req_addr   = restart ? cfg_base : next_addr;
	assign addr_step  = req_addr + 32'(dma_pkg::BURST_BYTES);
	assign region_end = cfg_base + cfg_len;
	assign addr_after = (addr_step >= region_end) ? cfg_base : addr_step;

	assign have_credit = (credits != 3'd0);

	// Free space not yet promised to outstanding bursts must fit a full burst
	assign space_ok = {1'b0, fifo_free} >= ({1'b0, reserved} + 7'(dma_pkg::BURST_BEATS));

	assign issue = cfg_enable && have_credit && space_ok;

	// Walk position
	always_ff @(posedge clk) begin
		if (!rst_n)
			next_addr <= '0;
		else if (issue)
			next_addr <= addr_after;
		else if (restart)
			next_addr <= cfg_base;
	end

	// Credit counter, one returned per pulse
	always_ff @(posedge clk) begin
		if (!rst_n)
			credits <= 3'(dma_pkg::MEM_CREDITS);
		else
			credits <= credits - {2'd0, issue} + {2'd0, mem_credit};
	end

	// Reserved FIFO space
	always_ff @(posedge clk) begin
		if (!rst_n)
			reserved <= '0;
		else
			reserved <= reserved + (issue ? 6'(dma_pkg::BURST_BEATS) : 6'd0)
				- {5'd0, beat_taken};
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			mem_req_valid <= 1'b0;
		else
			mem_req_valid <= issue; // One cycle per burst
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			mem_req.mode   <= dma_pkg::MEM_MODE_READ;
			mem_req.did    <= dma_pkg::DMAC_DID;
			mem_req.subdid <= dma_pkg::DMAC_SUBDID;
			mem_req.addr   <= req_addr;
			mem_req.len    <= 8'(dma_pkg::BURST_BEATS);
		end
	end

	// Credits only come back for requests that went out
	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= 3'(dma_pkg::MEM_CREDITS));

	// Every own beat belongs to a burst still outstanding
	a_beat_reserved: assert property (@(posedge clk) disable iff (!rst_n)
		beat_taken |-> reserved != 6'd0);

endmodule

`default_nettype wire

//--- design/dma_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dma_cfg_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              cfg_valid,
	input  dma_pkg::cfg_bus_t cfg,
	output logic [31:0]       cfg_rdata,
	output logic              cfg_rvalid,
	output logic [31:0]       cfg_base,
	output logic [31:0]       cfg_len,
	output logic              cfg_enable,
	output logic              restart
);

	logic hit;
	logic wr_en;
	logic rd_en;

	// Only accesses addressed to this device count
	assign hit   = cfg_valid && (cfg.did == dma_pkg::CFG_DID_DMAC);
	assign wr_en = hit && !cfg.r_nw;
	assign rd_en = hit && cfg.r_nw;

	// Register writes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg_base   <= '0;
			cfg_len    <= '0;
			cfg_enable <= 1'b0;
			restart    <= 1'b0;
		end else begin
			restart <= 1'b0;
			if (wr_en) begin
				case (cfg.addr)
					dma_pkg::REG_BASE: cfg_base <= cfg.data;
					dma_pkg::REG_LEN:  cfg_len  <= cfg.data;
					dma_pkg::REG_CTRL: begin
						cfg_enable <= cfg.data[0];
						restart    <= cfg.data[0]; // Walk starts over at base
					end
					default: ;
				endcase
			end
		end
	end

	// Read strobe is answered one cycle later
	always_ff @(posedge clk) begin
		if (!rst_n)
			cfg_rvalid <= 1'b0;
		else
			cfg_rvalid <= rd_en;
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			case (cfg.addr)
				dma_pkg::REG_BASE: cfg_rdata <= cfg_base;
				dma_pkg::REG_LEN:  cfg_rdata <= cfg_len;
				dma_pkg::REG_CTRL: cfg_rdata <= {31'd0, cfg_enable};
				default:           cfg_rdata <= '0; // Unmapped reads zero
			endcase
		end
	end

	// A strobed access carries defined fields
	a_cfg_known: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_valid |-> !$isunknown(cfg));

endmodule

`default_nettype wire

//--- design/dma_pkg.sv
`default_nettype none

package dma_pkg;

	// Memory request bus
	localparam logic [1:0] MEM_MODE_READ = 2'b01;
	localparam logic [3:0] DMAC_DID      = 4'h1;
	localparam logic [3:0] DMAC_SUBDID   = 4'h2;

	// Config bus device and register map
	localparam logic [3:0] CFG_DID_DMAC = 4'h3;
	localparam logic [7:0] REG_BASE     = 8'h00; // Base byte address
	localparam logic [7:0] REG_LEN      = 8'h04; // Region length in bytes
	localparam logic [7:0] REG_CTRL     = 8'h08; // Bit 0 is enable

	// Burst geometry
	localparam int BURST_BEATS = 8;
	localparam int BEAT_BYTES  = 8;
	localparam int BURST_BYTES = BURST_BEATS * BEAT_BYTES;

	// Flow control and buffering
	localparam int MEM_CREDITS = 4;
	localparam int FIFO_DEPTH  = 32;
	localparam int FIFO_AW     = 5;

	// One request on the memory request bus
	typedef struct packed {
		logic [1:0]  mode;
		logic [3:0]  did;
		logic [3:0]  subdid;
		logic [31:0] addr;  // Byte address
		logic [7:0]  len;   // Beat count
	} mem_req_t;

	// One response beat
	typedef struct packed {
		logic [3:0]  did;
		logic [3:0]  subdid;
		logic [63:0] data;
	} mem_resp_t;

	// One config bus access
	typedef struct packed {
		logic        r_nw;  // High for read
		logic [3:0]  did;
		logic [7:0]  addr;
		logic [31:0] data;
	} cfg_bus_t;

endpackage

`default_nettype wire

//--- design/dma_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dma_read_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic [31:0]        cfg_base,
	input  logic [31:0]        cfg_len,
	input  logic               cfg_enable,
	input  logic               restart,
	output logic               mem_req_valid,
	output dma_pkg::mem_req_t  mem_req,
	input  logic               mem_credit,
	input  logic               mem_resp_valid,
	input  dma_pkg::mem_resp_t mem_resp,
	input  logic               request,
	output logic [63:0]        data,
	output logic               data_ready,
	output logic               data_avail
);

	logic       beat_taken;
	logic       fifo_pop;
	logic       fifo_empty;
	logic [5:0] fifo_free;

	// Keep only beats addressed to this engine
	assign beat_taken = mem_resp_valid
		&& (mem_resp.did == dma_pkg::DMAC_DID)
		&& (mem_resp.subdid == dma_pkg::DMAC_SUBDID);

	assign fifo_pop   = request && !fifo_empty; // Requests on empty are dropped
	assign data_avail = !fifo_empty;

	// Word appears on data together with this strobe
	always_ff @(posedge clk) begin
		if (!rst_n)
			data_ready <= 1'b0;
		else
			data_ready <= fifo_pop;
	end

	dma_burst_issuer i_issuer (
		.clk           (clk),
		.rst_n         (rst_n),
		.cfg_base      (cfg_base),
		.cfg_len       (cfg_len),
		.cfg_enable    (cfg_enable),
		.restart       (restart),
		.mem_credit    (mem_credit),
		.beat_taken    (beat_taken),
		.fifo_free     (fifo_free),
		.mem_req_valid (mem_req_valid),
		.mem_req       (mem_req)
	);

	dma_word_fifo i_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (beat_taken),
		.push_data (mem_resp.data),
		.pop       (fifo_pop),
		.pop_data  (data),
		.empty     (fifo_empty),
		.free      (fifo_free)
	);

endmodule

`default_nettype wire

//--- design/dma_read_sys.sv
`timescale 1ns/1ps
`default_nettype none

module dma_read_sys (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cfg_valid,
	input  dma_pkg::cfg_bus_t  cfg,
	output logic [31:0]        cfg_rdata,
	output logic               cfg_rvalid,
	output logic               mem_req_valid,
	output dma_pkg::mem_req_t  mem_req,
	input  logic               mem_credit,
	input  logic               mem_resp_valid,
	input  dma_pkg::mem_resp_t mem_resp,
	input  logic               request,
	output logic [63:0]        data,
	output logic               data_ready,
	output logic               data_avail
);

	// Register levels into the read path
	logic [31:0] cfg_base;
	logic [31:0] cfg_len;
	logic        cfg_enable;
	logic        restart;

	dma_cfg_regs i_cfg_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg_valid  (cfg_valid),
		.cfg        (cfg),
		.cfg_rdata  (cfg_rdata),
		.cfg_rvalid (cfg_rvalid),
		.cfg_base   (cfg_base),
		.cfg_len    (cfg_len),
		.cfg_enable (cfg_enable),
		.restart    (restart)
	);

	dma_read_ctrl i_read_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg_base       (cfg_base),
		.cfg_len        (cfg_len),
		.cfg_enable     (cfg_enable),
		.restart        (restart),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_credit     (mem_credit),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp       (mem_resp),
		.request        (request),
		.data           (data),
		.data_ready     (data_ready),
		.data_avail     (data_avail)
	);

endmodule

`default_nettype wire

//--- design/dma_word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module dma_word_fifo (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        push,
	input  logic [63:0] push_data,
	input  logic        pop,
	output logic [63:0] pop_data,
	output logic        empty,
	output logic [5:0]  free
);

	logic [63:0] mem [dma_pkg::FIFO_DEPTH];

	logic [dma_pkg::FIFO_AW-1:0] wr_ptr;
	logic [dma_pkg::FIFO_AW-1:0] rd_ptr;
	logic [dma_pkg::FIFO_AW:0]   count;   // Occupancy, 0 to depth

	assign empty = (count == '0);
	assign free  = 6'(dma_pkg::FIFO_DEPTH) - count;

	// Storage has no reset
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// Registered read port
	always_ff @(posedge clk) begin
		if (pop)
			pop_data <= mem[rd_ptr];
	end

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			count <= '0;
		else
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> count != 6'(dma_pkg::FIFO_DEPTH));

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		pop |-> !empty);

endmodule

`default_nettype wire

//--- dma_read_sys.f
design/dma_pkg.sv
design/dma_cfg_regs.sv
design/dma_burst_issuer.sv
design/dma_word_fifo.sv
design/dma_read_ctrl.sv
design/dma_read_sys.sv
sim/tb_clock_gen.sv
sim/tb_mem_model.sv
sim/tb_dma_read_sys.sv

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	// Reset held low for a fixed number of rising edges
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/tb_dma_read_sys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_read_sys;

	localparam int CLK_PERIOD = 100;
	localparam int MEM_GAP    = 4;
	localparam int CONS_GAP   = 3;

	// Words moved over the whole run, drains included
	localparam int WORDS_TOTAL     = 100 + 40 + 50 + 2 * dma_pkg::FIFO_DEPTH;
	localparam int CYCLES_PER_WORD = (MEM_GAP + 1) * 2 + CONS_GAP + 4;
	localparam int FIXED_CYCLES    = 300 + 20 + 200;
	localparam int LIMIT_CYCLES    = 2 * (WORDS_TOTAL * CYCLES_PER_WORD + FIXED_CYCLES);

	logic               clk;
	logic               rst_n;
	logic               cfg_valid;
	dma_pkg::cfg_bus_t  cfg;
	logic [31:0]        cfg_rdata;
	logic               cfg_rvalid;
	logic               mem_req_valid;
	dma_pkg::mem_req_t  mem_req;
	logic               mem_credit;
	logic               mem_resp_valid;
	dma_pkg::mem_resp_t mem_resp;
	logic               request;
	logic [63:0]        data;
	logic               data_ready;
	logic               data_avail;
	logic               mem_idle;

	// Reference state kept from the config traffic
	logic [31:0]       base_sh;
	logic [31:0]       len_sh;
	logic              en_sh;
	logic [31:0]       req_exp;     // Address the next burst must carry
	logic [31:0]       word_idx;    // Words delivered since the last enable
	logic [31:0]       rd_expect_q;
	logic              rd_hit_q;
	logic              pop_q;
	logic [63:0]       exp_word;
	dma_pkg::mem_req_t req_expect;

	int outstanding;  // Requests minus returned credits
	int rx_cnt;
	int pop_cnt;
	int words_seen;

	logic cfg_hit;
	logic cfg_wr_hit;
	logic cfg_rd_hit;
	logic own_beat;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) i_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	tb_mem_model #(.MAX_GAP(MEM_GAP)) i_mem_model (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_credit     (mem_credit),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp       (mem_resp),
		.idle           (mem_idle)
	);

	dma_read_sys i_dma_read_sys (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg_valid      (cfg_valid),
		.cfg            (cfg),
		.cfg_rdata      (cfg_rdata),
		.cfg_rvalid     (cfg_rvalid),
		.mem_req_valid  (mem_req_valid),
		.mem_req        (mem_req),
		.mem_credit     (mem_credit),
		.mem_resp_valid (mem_resp_valid),
		.mem_resp       (mem_resp),
		.request        (request),
		.data           (data),
		.data_ready     (data_ready),
		.data_avail     (data_avail)
	);

	assign cfg_hit    = cfg_valid && (cfg.did == dma_pkg::CFG_DID_DMAC);
	assign cfg_wr_hit = cfg_hit && !cfg.r_nw;
	assign cfg_rd_hit = cfg_hit && cfg.r_nw;
	assign own_beat   = mem_resp_valid && (mem_resp.did == dma_pkg::DMAC_DID)
		&& (mem_resp.subdid == dma_pkg::DMAC_SUBDID);

	function automatic logic [31:0] reg_value(input logic [7:0] reg_addr);
		case (reg_addr)
			dma_pkg::REG_BASE: return base_sh;
			dma_pkg::REG_LEN:  return len_sh;
			dma_pkg::REG_CTRL: return {31'd0, en_sh};
			default:           return 32'd0;
		endcase
	endfunction

	// Burst walk with wrap at the region end
	function automatic logic [31:0] next_burst(input logic [31:0] addr);
		logic [31:0] step;
		step = addr + 32'(dma_pkg::BURST_BEATS * dma_pkg::BEAT_BYTES);
		return (step >= base_sh + len_sh) ? base_sh : step;
	endfunction

	always_comb begin
		exp_word = '0;
		if (len_sh != 0)
			exp_word = {32'd0, base_sh + ((word_idx * 32'(dma_pkg::BEAT_BYTES)) % len_sh)};
	end

	always_comb begin
		req_expect.mode   = dma_pkg::MEM_MODE_READ;
		req_expect.did    = dma_pkg::DMAC_DID;
		req_expect.subdid = dma_pkg::DMAC_SUBDID;
		req_expect.addr   = req_exp;
		req_expect.len    = 8'(dma_pkg::BURST_BEATS);
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			base_sh  <= '0;
			len_sh   <= '0;
			en_sh    <= 1'b0;
			req_exp  <= '0;
			word_idx <= '0;
		end else begin
			if (mem_req_valid)
				req_exp <= next_burst(req_exp);
			if (data_ready)
				word_idx <= word_idx + 1;
			if (cfg_wr_hit) begin
				case (cfg.addr)
					dma_pkg::REG_BASE: base_sh <= cfg.data;
					dma_pkg::REG_LEN:  len_sh  <= cfg.data;
					dma_pkg::REG_CTRL: begin
						en_sh <= cfg.data[0];
						if (cfg.data[0]) begin // Stream starts over at base
							req_exp  <= base_sh;
							word_idx <= '0;
						end
					end
					default: ;
				endcase
			end
		end
		if (cfg_rd_hit)
			rd_expect_q <= reg_value(cfg.addr);
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			outstanding <= 0;
			rx_cnt      <= 0;
			pop_cnt     <= 0;
			words_seen  <= 0;
			pop_q       <= 1'b0;
			rd_hit_q    <= 1'b0;
		end else begin
			outstanding <= outstanding + int'(mem_req_valid) - int'(mem_credit);
			if (own_beat)
				rx_cnt <= rx_cnt + 1;
			if (request && data_avail)
				pop_cnt <= pop_cnt + 1;
			if (data_ready)
				words_seen <= words_seen + 1;
			pop_q    <= request && data_avail;
			rd_hit_q <= cfg_rd_hit;
		end
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	a_reset_state: assert property (@(posedge clk)
		!rst_n |=> !mem_req_valid && !cfg_rvalid && !data_ready && !data_avail)
		else stop_on_error($sformatf({"Error at %0t: reset outputs mem_req_valid=%b ",
			"cfg_rvalid=%b data_ready=%b data_avail=%b, expected all 0"}, $time,
			$sampled(mem_req_valid), $sampled(cfg_rvalid), $sampled(data_ready),
			$sampled(data_avail)));

	a_rvalid_timing: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_rvalid == rd_hit_q)
		else stop_on_error($sformatf("Error at %0t: cfg_rvalid = %b, expected %b",
			$time, $sampled(cfg_rvalid), $sampled(rd_hit_q)));

	a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_rvalid |-> cfg_rdata == rd_expect_q)
		else stop_on_error($sformatf("Error at %0t: cfg_rdata = %h, expected %h",
			$time, $sampled(cfg_rdata), $sampled(rd_expect_q)));

	a_req_fields: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid |-> mem_req == req_expect)
		else stop_on_error($sformatf("Error at %0t: mem_req = %h, expected %h",
			$time, $sampled(mem_req), $sampled(req_expect)));

	a_no_req_disabled: assert property (@(posedge clk) disable iff (!rst_n)
		!en_sh && !$past(en_sh) |-> !mem_req_valid)
		else stop_on_error($sformatf("Error at %0t: mem_req_valid = %b, expected 0",
			$time, $sampled(mem_req_valid)));

	a_data_value: assert property (@(posedge clk) disable iff (!rst_n)
		data_ready |-> data == exp_word)
		else stop_on_error($sformatf("Error at %0t: data = %h, expected %h",
			$time, $sampled(data), $sampled(exp_word)));

	a_no_marker: assert property (@(posedge clk) disable iff (!rst_n)
		data_ready |-> data != '1)
		else stop_on_error($sformatf("Error at %0t: data = %h, a foreign beat reached output",
			$time, $sampled(data)));

	a_ready_timing: assert property (@(posedge clk) disable iff (!rst_n)
		data_ready == pop_q)
		else stop_on_error($sformatf("Error at %0t: data_ready = %b, expected %b",
			$time, $sampled(data_ready), $sampled(pop_q)));

	// Words held are own beats received minus words popped
	a_avail: assert property (@(posedge clk) disable iff (!rst_n)
		data_avail == (rx_cnt != pop_cnt))
		else stop_on_error($sformatf("Error at %0t: data_avail = %b, expected %b",
			$time, $sampled(data_avail), $sampled(rx_cnt != pop_cnt)));

	a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		outstanding <= dma_pkg::MEM_CREDITS)
		else stop_on_error($sformatf("Error at %0t: outstanding requests = %0d, expected <= %0d",
			$time, $sampled(outstanding), dma_pkg::MEM_CREDITS));

	a_fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
		rx_cnt - pop_cnt <= dma_pkg::FIFO_DEPTH)
		else stop_on_error($sformatf("Error at %0t: buffered beats = %0d, expected <= %0d",
			$time, $sampled(rx_cnt - pop_cnt), dma_pkg::FIFO_DEPTH));

	task automatic cfg_write(input logic [7:0] reg_addr, input logic [31:0] value);
		@(posedge clk);
		cfg_valid <= 1'b1;
		cfg       <= '{r_nw: 1'b0, did: dma_pkg::CFG_DID_DMAC, addr: reg_addr, data: value};
		@(posedge clk);
		cfg_valid <= 1'b0;
	endtask

	task automatic cfg_read(input logic [3:0] did, input logic [7:0] reg_addr);
		@(posedge clk);
		cfg_valid <= 1'b1;
		cfg       <= '{r_nw: 1'b1, did: did, addr: reg_addr, data: 32'd0};
		@(posedge clk);
		cfg_valid <= 1'b0;
	endtask

	// Pulses request until n more words came back, with random gaps
	task automatic consume(input int n, input int max_gap);
		int target;
		target = words_seen + n;
		while (words_seen < target) begin
			@(posedge clk);
			request <= 1'b1;
			@(posedge clk);
			request <= 1'b0;
			repeat ($urandom_range(1, max_gap + 1)) @(posedge clk);
			@(negedge clk);
		end
	endtask

	// Empties the FIFO and waits for the memory side to go quiet
	task automatic drain();
		@(negedge clk);
		while (data_avail || !mem_idle || mem_req_valid || mem_resp_valid) begin
			@(posedge clk);
			request <= 1'b1;
			@(posedge clk);
			request <= 1'b0;
			@(negedge clk);
		end
	endtask

	initial begin
		void'($urandom(32'hf218_c65a));
		cfg_valid = 1'b0;
		cfg       = '0;
		request   = 1'b0;
		@(posedge rst_n);
		@(posedge clk);

		cfg_write(dma_pkg::REG_BASE, 32'h1000);
		cfg_write(dma_pkg::REG_LEN, 32'd256);
		cfg_write(dma_pkg::REG_CTRL, 32'd1);
		cfg_read(dma_pkg::CFG_DID_DMAC, dma_pkg::REG_BASE);
		cfg_read(dma_pkg::CFG_DID_DMAC, dma_pkg::REG_LEN);
		cfg_read(dma_pkg::CFG_DID_DMAC, dma_pkg::REG_CTRL);
		cfg_read(dma_pkg::CFG_DID_DMAC, 8'h0c);                 // Unmapped
		cfg_read(dma_pkg::CFG_DID_DMAC + 4'd1, dma_pkg::REG_BASE); // Other device

		consume(100, CONS_GAP);  // Several wraps of the 256 byte region
		repeat (300) @(posedge clk); // Consumer paused, FIFO fills
		consume(40, 1);

		cfg_write(dma_pkg::REG_CTRL, 32'd0);
		drain();
		repeat (20) @(posedge clk);
		cfg_write(dma_pkg::REG_BASE, 32'h2000);
		cfg_write(dma_pkg::REG_LEN, 32'd128);
		cfg_read(dma_pkg::CFG_DID_DMAC, dma_pkg::REG_BASE);
		cfg_write(dma_pkg::REG_CTRL, 32'd1);
		consume(50, 2);

		cfg_write(dma_pkg::REG_CTRL, 32'd0);
		drain();
		repeat (5) @(posedge clk);
		$display("PASS: all tests");
		$finish;
	end

	// Watchdog
	initial begin
		#(LIMIT_CYCLES * CLK_PERIOD);
		stop_on_error("Timeout: the test sequence did not finish in the allowed time");
	end

endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
	parameter int MAX_GAP = 4 // Longest credit delay and gap between beats
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               mem_req_valid,
	input  dma_pkg::mem_req_t  mem_req,
	output logic               mem_credit,
	output logic               mem_resp_valid,
	output dma_pkg::mem_resp_t mem_resp,
	output logic               idle
);

	logic               credit_r   = 1'b0;
	logic               resp_vld_r = 1'b0;
	dma_pkg::mem_resp_t resp_r     = '0;
	logic               idle_r     = 1'b1;

	logic [31:0] addr_q[$];   // Bursts still to be answered
	int          credit_q[$]; // Cycle at which each credit goes back
	int          cycle;
	int          gap;         // Cycles left before the next own beat
	int          beat;
	int          due;

	assign mem_credit     = credit_r;
	assign mem_resp_valid = resp_vld_r;
	assign mem_resp       = resp_r;
	assign idle           = idle_r;

	always @(posedge clk) begin
		if (!rst_n) begin
			credit_r   <= 1'b0;
			resp_vld_r <= 1'b0;
			resp_r     <= '0;
			idle_r     <= 1'b1;
			addr_q.delete();
			credit_q.delete();
			cycle = 0;
			gap   = 0;
			beat  = 0;
		end else begin
			credit_r   <= 1'b0;
			resp_vld_r <= 1'b0;
			if (mem_req_valid) begin
				addr_q.push_back(mem_req.addr);
				due = cycle + 1 + $urandom_range(0, MAX_GAP);
				if (credit_q.size() != 0 && due <= credit_q[$])
					due = credit_q[$] + 1; // Credits return one per cycle, in order
				credit_q.push_back(due);
			end
			if (credit_q.size() != 0 && credit_q[0] <= cycle) begin
				credit_r <= 1'b1;
				void'(credit_q.pop_front());
			end
			if (gap != 0) begin
				gap = gap - 1;
				// Foreign beat slipped in between own beats
				if ($urandom_range(0, 2) == 0) begin
					resp_vld_r <= 1'b1;
					if ($urandom_range(0, 1) == 0)
						resp_r <= '{did: dma_pkg::DMAC_DID + 4'd1,
							subdid: dma_pkg::DMAC_SUBDID, data: '1};
					else
						resp_r <= '{did: dma_pkg::DMAC_DID,
							subdid: dma_pkg::DMAC_SUBDID ^ 4'hf, data: '1};
				end
			end else if (addr_q.size() != 0) begin
				resp_vld_r <= 1'b1;
				resp_r     <= '{did: dma_pkg::DMAC_DID, subdid: dma_pkg::DMAC_SUBDID,
					data: 64'(addr_q[0] + 32'(beat * dma_pkg::BEAT_BYTES))};
				beat = beat + 1;
				if (beat == dma_pkg::BURST_BEATS) begin
					beat = 0;
					void'(addr_q.pop_front());
				end
				gap = $urandom_range(0, MAX_GAP);
			end
			idle_r <= (addr_q.size() == 0) && (credit_q.size() == 0);
			cycle = cycle + 1;
		end
	end

endmodule

`default_nettype wire
